/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word address width of the core
`define MEM_ADDR_BITS 18

// Core depth in words, 256K for simulation
`define MEM_DEPTH (1 << `MEM_ADDR_BITS)

// KL10 data word, bits 0 to 35
`define MEM_WORD_BITS 36

// ACKN pulse length in SBUS cycles
`define ACK_CYCLES 2

// VALID pulse length in SBUS cycles
`define VALID_CYCLES 2

`endif

/* sbus_pkg.sv */
`include "mem_params.svh"

package sbusPkg;

  // Quadword request as presented with START
  typedef struct packed {
    // Request mask, bit 0 is the first word
    logic [0:3] rq;
    // Word address, low two bits give the starting offset
    logic [`MEM_ADDR_BITS-1:0] adr;
    // High for a write cycle
    logic write;
    // Write data in KL10 bit order
    logic [0:`MEM_WORD_BITS-1] wdata;
    // Parity over wdata as sent by the requester
    logic wpar;
  } sbusReq;

  // Memory side of the bus
  typedef struct packed {
    // Word acknowledge, two cycles per word
    logic ackn;
    // Read data valid, two cycles per word
    logic valid;
    // Read data, zero outside VALID
    logic [0:`MEM_WORD_BITS-1] d;
    // XOR over d
    logic dataPar;
  } sbusResp;

endpackage

/* mem_pkg.sv */
`include "mem_params.svh"

package memPkg;

  // One core word, numbered 0 to 35 as on the KL10
  typedef logic [0:`MEM_WORD_BITS-1] memWord;

  // Word address; bits 1:0 are the offset inside the quadword
  typedef logic [`MEM_ADDR_BITS-1:0] memAddr;

  // Sequencer phases, same walk as the MB20 phase machine
  typedef enum logic [2:0] {
    IDLE,
    ACK1,
    ACK2,
    ACKtoREAD,
    READ1,
    READ2,
    SHIFT,
    WAITIDLE
  } seqState;

  // Bus parity is the plain XOR of all data bits
  function automatic logic wordPar(memWord w);
    return ^w;
  endfunction

endpackage

/* sbusRequestPort.sv */
`timescale 1ns/1ps

module sbusRequestPort (
  input  logic            SBUS,
  input  logic            reset,
  input  logic            start,
  input  sbusPkg::sbusReq req,
  input  logic            take,
  output logic            pendValid,
  output sbusPkg::sbusReq pend,
  output logic            pendParOk
);
  import memPkg::*;

  // One-entry request slot
  //
  // START is a single-cycle strobe with req stable. The next START
  // may come while the sequencer still drives VALID for the previous
  // request, so the slot decouples the bus from the sequencer.

  // Slot occupancy
  always_ff @(posedge SBUS) begin
    if (reset) begin
      pendValid <= 1'b0;
    end else if (start) begin
      // New request wins over a take in the same cycle
      pendValid <= 1'b1;
    end else if (take) begin
      // Sequencer latched the request, slot is free again
      pendValid <= 1'b0;
    end
  end

  // Slot payload
  always_ff @(posedge SBUS) begin
    if (start) begin
      pend <= req;
      // Check write parity once at capture
      pendParOk <= (req.wpar == wordPar(req.wdata));
    end
  end

endmodule

/* quadwordSequencer.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module quadwordSequencer (
  input  logic            SBUS,
  input  logic            reset,
  input  logic            pendValid,
  input  sbusPkg::sbusReq pend,
  input  logic            pendParOk,
  output logic            take,
  output logic            rdEn,
  output logic            wrEn,
  output memPkg::memAddr  addr,
  output memPkg::memWord  wdata,
  output logic            ackOn,
  output logic            validOn,
  output logic            parErr
);
  import memPkg::*;

  seqState    state;
  seqState    next;
  // Words not yet acknowledged, bit 0 is the current one
  logic [0:3] toAck;
  // Quadword base taken from the request
  memAddr     baseAddr;
  // Word offset, steps mod 4 on each word read
  logic [1:0] wo;
  memWord     wdataReg;
  logic       isWrite;
  // Only the first word of a write is stored
  logic       writePending;
  logic       parOkReg;
  // Cycles spent in ACK2 or READ2
  logic [3:0] phaseCnt;
  logic       ackDone;
  logic       readDone;

  // ACK1 and READ1 give the first pulse cycle, the *2 states the rest
  assign ackDone  = (phaseCnt == 4'(`ACK_CYCLES - 2));
  assign readDone = (phaseCnt == 4'(`VALID_CYCLES - 2));

  // Next state
  always_comb begin
    next = state;
    case (state)
      IDLE: begin
        if (pendValid) begin
          next = pend.rq[0] ? ACK1 : SHIFT;
        end
      end
      ACK1: next = ACK2;
      ACK2: begin
        if (ackDone) begin
          next = ACKtoREAD;
        end
      end
      // Writes commit here and skip the read cycles
      ACKtoREAD: next = isWrite ? SHIFT : READ1;
      READ1: next = READ2;
      READ2: begin
        if (readDone) begin
          next = SHIFT;
        end
      end
      SHIFT: begin
        if (toAck[1]) begin
          next = ACK1;
        end else if (toAck[1:3] == 3'b000) begin
          next = WAITIDLE;
        end
        // Otherwise stay and shift a clear mask bit through
      end
      WAITIDLE: next = IDLE;
      default: next = IDLE;
    endcase
  end

  // Control state
  always_ff @(posedge SBUS) begin
    if (reset) begin
      state        <= IDLE;
      toAck        <= 4'b0000;
      phaseCnt     <= 4'd0;
      isWrite      <= 1'b0;
      writePending <= 1'b0;
      parErr       <= 1'b0;
    end else begin
      state <= next;
      // One-cycle flag for a write that failed its parity check
      parErr <= (state == ACKtoREAD) && writePending && !parOkReg;
      if (state == ACK1 || state == READ1) begin
        phaseCnt <= 4'd0;
      end else if (state == ACK2 || state == READ2) begin
        phaseCnt <= phaseCnt + 4'd1;
      end
      case (state)
        IDLE: begin
          if (pendValid) begin
            toAck        <= pend.rq;
            isWrite      <= pend.write;
            writePending <= pend.write && pend.rq[0];
          end
        end
        ACKtoREAD: writePending <= 1'b0;
        SHIFT: toAck <= toAck << 1;
        default: ;
      endcase
    end
  end

  // Request payload and word offset
  always_ff @(posedge SBUS) begin
    if (take) begin
      baseAddr <= pend.adr;
      wo       <= pend.adr[1:0];
      wdataReg <= pend.wdata;
      parOkReg <= pendParOk;
    end else if (state == READ1) begin
      wo <= wo + 2'd1;
    end
  end

  assign take    = (state == IDLE) && pendValid;
  // Array read one cycle ahead of READ1 so data is ready for VALID
  assign rdEn    = (state == ACKtoREAD) && !isWrite;
  assign wrEn    = (state == ACKtoREAD) && writePending && parOkReg;
  assign addr    = {baseAddr[`MEM_ADDR_BITS-1:2], wo};
  assign wdata   = wdataReg;
  assign ackOn   = (state == ACK1) || (state == ACK2);
  assign validOn = (state == READ1) || (state == READ2);

endmodule

/* coreArray.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module coreArray (
  input  logic           SBUS,
  input  logic           rdEn,
  input  logic           wrEn,
  input  memPkg::memAddr addr,
  input  memPkg::memWord wdata,
  output memPkg::memWord rdata
);
  import memPkg::*;

  // Core store, cleared at start of simulation
  memWord mem [`MEM_DEPTH] = '{default: '0};

  // Synchronous write
  always_ff @(posedge SBUS) begin
    if (wrEn) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read
  // rdata holds while rdEn is low, which covers the whole VALID pulse
  always_ff @(posedge SBUS) begin
    if (rdEn) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* sbusResponseDriver.sv */
`timescale 1ns/1ps

module sbusResponseDriver (
  input  logic             SBUS,
  input  logic             reset,
  input  logic             ackOn,
  input  logic             validOn,
  input  memPkg::memWord   rdata,
  output sbusPkg::sbusResp resp
);
  import memPkg::*;

  logic   acknReg;
  logic   validReg;
  memWord dReg;
  logic   parReg;

  // Bus strobes, one register behind the sequencer state
  always_ff @(posedge SBUS) begin
    if (reset) begin
      acknReg  <= 1'b0;
      validReg <= 1'b0;
    end else begin
      acknReg  <= ackOn;
      validReg <= validOn;
    end
  end

  // Data and parity only while VALID is up, zero otherwise
  always_ff @(posedge SBUS) begin
    if (validOn) begin
      dReg   <= rdata;
      parReg <= wordPar(rdata);
    end else begin
      dReg   <= '0;
      parReg <= 1'b0;
    end
  end

  assign resp = '{ackn: acknReg, valid: validReg, d: dReg, dataPar: parReg};

endmodule

/* mb20Memory.sv */
`timescale 1ns/1ps

module mb20Memory (
  input  logic             SBUS,
  input  logic             reset,
  input  logic             start,
  input  sbusPkg::sbusReq  req,
  output sbusPkg::sbusResp resp,
  output logic             parErr
);
  import sbusPkg::*;
  import memPkg::*;

  // Slot to sequencer
  logic   pendValid;
  logic   pendParOk;
  logic   take;
  sbusReq pend;
  // Sequencer to array
  logic   rdEn;
  logic   wrEn;
  memAddr addr;
  memWord wdata;
  memWord rdata;
  // Sequencer to bus driver
  logic   ackOn;
  logic   validOn;

  // Input side
  sbusRequestPort reqPort_i (
    .SBUS      (SBUS),
    .reset     (reset),
    .start     (start),
    .req       (req),
    .take      (take),
    .pendValid (pendValid),
    .pend      (pend),
    .pendParOk (pendParOk)
  );

  // Phase machine
  quadwordSequencer seq_i (
    .SBUS      (SBUS),
    .reset     (reset),
    .pendValid (pendValid),
    .pend      (pend),
    .pendParOk (pendParOk),
    .take      (take),
    .rdEn      (rdEn),
    .wrEn      (wrEn),
    .addr      (addr),
    .wdata     (wdata),
    .ackOn     (ackOn),
    .validOn   (validOn),
    .parErr    (parErr)
  );

  // Core store
  coreArray core_i (
    .SBUS  (SBUS),
    .rdEn  (rdEn),
    .wrEn  (wrEn),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata)
  );

  // Output side
  sbusResponseDriver respDrv_i (
    .SBUS    (SBUS),
    .reset   (reset),
    .ackOn   (ackOn),
    .validOn (validOn),
    .rdata   (rdata),
    .resp    (resp)
  );

endmodule

/* mb20_checker.sv */
`timescale 1ns/1ps

module mb20_checker (
  input logic             SBUS,
  input logic             reset,
  input sbusPkg::sbusResp resp,
  input logic             parErr
);

  // ACKN and VALID never share a cycle
  noOverlap: assert property (@(posedge SBUS) disable iff (reset)
    !(resp.ackn && resp.valid))
    else $error("ACKN and VALID high in the same cycle");

  // ACKN pulse is two cycles
  acknLength: assert property (@(posedge SBUS) disable iff (reset)
    $rose(resp.ackn) |=> resp.ackn ##1 !resp.ackn)
    else $error("ACKN pulse is not two cycles long");

  // VALID pulse is two cycles
  validLength: assert property (@(posedge SBUS) disable iff (reset)
    $rose(resp.valid) |=> resp.valid ##1 !resp.valid)
    else $error("VALID pulse is not two cycles long");

  // Synchronous reset, outputs low from the first reset edge on
  resetState: assert property (@(posedge SBUS)
    $past(reset) |-> !resp.ackn && !resp.valid && !parErr)
    else $error("Bus outputs not low during reset");

endmodule

bind mb20Memory mb20_checker chk_i (
  .SBUS   (SBUS),
  .reset  (reset),
  .resp   (resp),
  .parErr (parErr)
);

/* tb_mb20.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mb20;
  import sbusPkg::*;
  import memPkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int N_WRITE      = 20;
  localparam int N_WRAP       = 12;
  localparam int N_SPARSE     = 30;
  localparam int N_BAD        = 6;
  localparam int N_B2B        = 8;
  // Request count over all tests, sizes the watchdog
  localparam int TOTAL_REQ    = 1 + 2 * N_WRITE + N_WRAP + N_SPARSE + 2 * N_BAD + 2 * N_B2B;
  localparam int TIMEOUT_NS   = (TOTAL_REQ * 40 + 100) * CLK_PERIOD;
  // Bound on one request, a full-mask read needs about 30 cycles
  localparam int REQ_LIMIT    = 60;
  // Idle cycles after the last pulse, catches stray ACKN or VALID
  localparam int QUIET_CYCLES = 5;

  logic    SBUS;
  logic    reset;
  logic    start;
  sbusReq  req;
  sbusResp resp;
  logic    parErr;

  integer  seed;
  int      errors;
  int      testErrStart;
  int      testsPassed;
  int      testsFailed;

  // Reference store, absent entries read as zero
  memWord  modelMem [memAddr];
  memAddr  wrAddrs[$];
  // Expected response
  memWord  expData[$];
  int      expAckTotal;
  int      expParErrTotal;
  // Observed response
  memWord  gotData[$];
  logic    gotPar[$];
  int      ackCount;
  int      parErrCount;
  logic    prevAckn;
  logic    prevValid;
  logic    prevParErr;

  mb20Memory dut_i (
    .SBUS   (SBUS),
    .reset  (reset),
    .start  (start),
    .req    (req),
    .resp   (resp),
    .parErr (parErr)
  );

  initial SBUS = 1'b0;
  always #(CLK_PERIOD / 2) SBUS = ~SBUS;

  // Collector, samples mid-cycle and counts rising edges
  always @(negedge SBUS) begin
    if (reset) begin
      prevAckn   = 1'b0;
      prevValid  = 1'b0;
      prevParErr = 1'b0;
    end else begin
      if (resp.ackn && !prevAckn) begin
        ackCount++;
      end
      // Data is steady for the whole VALID pulse
      if (resp.valid && !prevValid) begin
        gotData.push_back(resp.d);
        gotPar.push_back(resp.dataPar);
      end
      if (parErr && !prevParErr) begin
        parErrCount++;
      end
      prevAckn   = resp.ackn;
      prevValid  = resp.valid;
      prevParErr = parErr;
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error: at %0t, %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic memWord readModel(input memAddr a);
    if (modelMem.exists(a)) begin
      return modelMem[a];
    end
    return '0;
  endfunction

  function automatic memWord randWord();
    return memWord'({$random(seed), $random(seed)});
  endfunction

  // Low 256 words plus the top address bits, so reads hit written words
  function automatic memAddr randAddr();
    logic [31:0] r;
    r = $random(seed);
    return memAddr'(r) & 18'h300ff;
  endfunction

  function automatic memAddr pickWritten();
    logic [31:0] r;
    int          idx;
    r   = $random(seed);
    idx = r % wrAddrs.size();
    return wrAddrs[idx];
  endfunction

  // Request with correct write parity
  function automatic sbusReq makeReq(input logic wr, input logic [0:3] mask,
                                     input memAddr a, input memWord w);
    sbusReq r;
    r.rq    = mask;
    r.adr   = a;
    r.write = wr;
    r.wdata = w;
    r.wpar  = ^w;
    return r;
  endfunction

  // Expected pulses and words, model update for writes
  task automatic predict(input sbusReq r);
    int         n;
    logic [1:0] offs;
    memAddr     a;
    n = 0;
    for (int k = 0; k < 4; k++) begin
      if (r.rq[k]) begin
        expAckTotal++;
        // Offset steps only on words actually read, wraps in the quadword
        if (!r.write) begin
          offs = r.adr[1:0] + 2'(n);
          a    = {r.adr[`MEM_ADDR_BITS-1:2], offs};
          expData.push_back(readModel(a));
          n++;
        end
      end
    end
    if (r.write && r.rq[0]) begin
      if (r.wpar == ^r.wdata) begin
        modelMem[r.adr] = r.wdata;
      end else begin
        expParErrTotal++;
      end
    end
  endtask

  // One-cycle START on the falling edge
  task automatic sendRequest(input sbusReq r);
    @(negedge SBUS);
    start = 1'b1;
    req   = r;
    @(negedge SBUS);
    start = 1'b0;
    req   = '0;
  endtask

  task automatic waitFirstAck(input int ackBefore);
    int cycles;
    cycles = 0;
    while (ackCount <= ackBefore && cycles < REQ_LIMIT) begin
      @(posedge SBUS);
      cycles++;
    end
    if (ackCount <= ackBefore) begin
      $display("No ACKN arrived within %0d cycles at %0t", REQ_LIMIT, $time);
      errors++;
    end
  endtask

  // Wait for all expected pulses, then compare against the model
  task automatic finishRequest();
    int     cycles;
    memWord expWord;
    memWord gotWord;
    logic   gotBit;
    cycles = 0;
    while ((ackCount < expAckTotal || gotData.size() < expData.size())
           && cycles < REQ_LIMIT) begin
      @(posedge SBUS);
      cycles++;
    end
    if (ackCount < expAckTotal || gotData.size() < expData.size()) begin
      $display("Request did not complete within %0d cycles at %0t", REQ_LIMIT, $time);
      errors++;
    end
    repeat (QUIET_CYCLES) @(posedge SBUS);
    checkValue("ACKN pulses", 64'(expAckTotal), 64'(ackCount));
    checkValue("parErr pulses", 64'(expParErrTotal), 64'(parErrCount));
    checkValue("VALID pulses", 64'(expData.size()), 64'(gotData.size()));
    while (expData.size() > 0 && gotData.size() > 0) begin
      expWord = expData.pop_front();
      gotWord = gotData.pop_front();
      gotBit  = gotPar.pop_front();
      checkValue("resp.d", 64'(expWord), 64'(gotWord));
      checkValue("resp.dataPar", 64'(^expWord), 64'(gotBit));
    end
    // Resync so one miss does not spill into later requests
    expData.delete();
    gotData.delete();
    gotPar.delete();
    expAckTotal    = ackCount;
    expParErrTotal = parErrCount;
  endtask

  task automatic runRequest(input sbusReq r);
    predict(r);
    sendRequest(r);
    finishRequest();
  endtask

  task automatic endTest(input string name);
    if (errors == testErrStart) begin
      testsPassed++;
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errors - testErrStart);
    end
    testErrStart = errors;
  endtask

  initial begin
    logic [31:0] r;
    memAddr      a;
    logic [0:3]  mask;
    sbusReq      first;
    sbusReq      second;
    int          ackBefore;
    seed           = 32'h22dd_62db;
    errors         = 0;
    testErrStart   = 0;
    testsPassed    = 0;
    testsFailed    = 0;
    expAckTotal    = 0;
    expParErrTotal = 0;
    ackCount       = 0;
    parErrCount    = 0;
    reset          = 1'b1;
    start          = 1'b0;
    req            = '0;
    repeat (5) @(negedge SBUS);
    reset = 1'b0;

    // Outputs idle, core reads back as zero
    checkValue("resp.ackn", 64'd0, 64'(resp.ackn));
    checkValue("resp.valid", 64'd0, 64'(resp.valid));
    checkValue("parErr", 64'd0, 64'(parErr));
    runRequest(makeReq(1'b0, 4'b1111, '0, '0));
    endTest("reset state");

    for (int i = 0; i < N_WRITE; i++) begin
      a = randAddr();
      wrAddrs.push_back(a);
      runRequest(makeReq(1'b1, 4'b1000, a, randWord()));
    end
    for (int i = 0; i < N_WRITE; i++) begin
      runRequest(makeReq(1'b0, 4'b1000, wrAddrs[i], '0));
    end
    endTest("write then read back");

    for (int i = 0; i < N_WRAP; i++) begin
      a      = pickWritten();
      r      = $random(seed);
      a[1:0] = r[1:0];
      runRequest(makeReq(1'b0, 4'b1111, a, '0));
    end
    endTest("quadword wraparound");

    // First mask is empty, the rest random
    for (int i = 0; i < N_SPARSE; i++) begin
      r    = $random(seed);
      mask = (i == 0) ? 4'b0000 : r[3:0];
      a    = r[6] ? pickWritten() : randAddr();
      runRequest(makeReq(r[5:4] == 2'b00, mask, a, randWord()));
    end
    endTest("sparse masks");

    for (int i = 0; i < N_BAD; i++) begin
      a          = pickWritten();
      first      = makeReq(1'b1, 4'b1000, a, randWord());
      first.wpar = ~first.wpar;
      runRequest(first);
      runRequest(makeReq(1'b0, 4'b1000, a, '0));
    end
    endTest("bad write parity");

    // Second START follows the first ACKN of the earlier request
    for (int i = 0; i < N_B2B; i++) begin
      r      = $random(seed);
      first  = makeReq(1'b0, r[3:0] | 4'b0001, pickWritten(), '0);
      second = makeReq(r[4], r[7:4] | 4'b1000, pickWritten(), randWord());
      predict(first);
      predict(second);
      ackBefore = ackCount;
      sendRequest(first);
      waitFirstAck(ackBefore);
      sendRequest(second);
      finishRequest();
    end
    endTest("back-to-back requests");

    $display("Summary: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed, errors);
    if (testsFailed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
sbus_pkg.sv
mem_pkg.sv
sbusRequestPort.sv
quadwordSequencer.sv
coreArray.sv
sbusResponseDriver.sv
mb20Memory.sv
mb20_checker.sv
tb_mb20.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_mb20, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_mb20 -f vlog.f -o Vtb_mb20
	./obj_dir/Vtb_mb20 | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
